//--- hdl/ptw_settings.svh
// Size and transaction-id constants for the page-table walker.
// The miss queue depth must stay at 8 or below, because the queue
// index type carries three position bits and a "none" flag above them.
// Transaction ids run from 1 to 15. Slot 0 of the buffer is never used.
// Pages are 4 KiB and each PTE is 8 bytes.

`ifndef PTW_SETTINGS_SVH
`define PTW_SETTINGS_SVH

// Miss queue and transaction buffer depths
`define PTW_MISSQ_SIZE 8
`define PTW_TRAN_SLOTS 16

// Fixed fields placed in every outgoing transaction id
`define PTW_CORENO 6'd1
`define PTW_CHANNEL 3'd3

// Address geometry: page offset width and log2 of the PTE size in bytes
`define PTW_PAGE_SHIFT 12
`define PTW_PTE_SHIFT 3

`endif

//--- hdl/ptw_pkg.sv
// Shared types for the page-table walker.
// Index types carry a "none selected" flag in their top bit.
// The page table has a single level, so entries hold no level field.

package ptw_pkg;

	typedef logic [7:0]  asid_t;
	typedef logic [31:0] vadr_t;
	typedef logic [31:0] padr_t;

	// Bit 0 is the valid bit, bits 51 to 12 hold the physical page number
	typedef logic [63:0] pte_t;

	typedef struct packed {
		logic [5:0] core;
		logic [2:0] channel;
		logic [3:0] tranid;
	} tran_id_t;

	typedef logic [3:0] missq_idx_t;
	typedef logic [4:0] slot_idx_t;

	// Index values with only the top bit set mean that nothing is selected
	localparam missq_idx_t MISSQ_NONE = 4'b1000;
	localparam slot_idx_t  SLOT_NONE  = 5'b10000;

	typedef struct packed {
		logic  valid;
		logic  issued;
		asid_t asid;
		vadr_t vadr;
	} missq_entry_t;

	typedef struct packed {
		logic         v;
		logic         rdy;
		tran_id_t     id;
		asid_t        asid;
		vadr_t        vadr;
		padr_t        padr;
		missq_idx_t   stk;
		logic [127:0] dat;
		pte_t         pte;
	} tran_buf_t;

	typedef enum logic {IDLE, ISSUE} ptw_state_t;

endpackage

//--- hdl/ptw_miss_queue.sv
// Miss queue between the TLB and the walker.
// A miss is taken only in a cycle where miss_busy is low, and the TLB
// must repeat any miss offered while the queue is full.
// Misses to a page that is already queued are merged into that entry.
// Ages count the younger valid entries, so the oldest entry has the top age.

`include "ptw_settings.svh"

module ptw_miss_queue import ptw_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       miss_v,
	input  asid_t      miss_asid,
	input  vadr_t      miss_vadr,
	input  missq_idx_t issue_qe,
	input  logic       done_v,
	input  missq_idx_t done_stk,
	output logic       miss_busy,
	output missq_idx_t sel_qe,
	output asid_t      sel_asid,
	output vadr_t      sel_vadr
);

	localparam int QAW = $clog2(`PTW_MISSQ_SIZE);

	missq_entry_t   q   [`PTW_MISSQ_SIZE];
	logic [QAW-1:0] age [`PTW_MISSQ_SIZE];

	logic           hit;
	logic           accept;
	logic [QAW-1:0] free_pos;
	logic           sel_found;
	logic [QAW-1:0] sel_pos;
	logic [QAW-1:0] sel_age;
	logic [QAW-1:0] done_age;

	// ==============================
	// Lookup, allocation and selection
	// ==============================
	always_comb begin
		hit = 1'b0;
		miss_busy = 1'b1;
		free_pos = '0;
		sel_found = 1'b0;
		sel_pos = '0;
		sel_age = '0;
		// Walk downward so that the lowest free entry is the last one written
		for (int i = `PTW_MISSQ_SIZE - 1; i >= 0; i--) begin
			if (!q[i].valid) begin
				miss_busy = 1'b0;
				free_pos = QAW'(i);
			end
			else if (q[i].asid == miss_asid &&
				q[i].vadr[31:`PTW_PAGE_SHIFT] == miss_vadr[31:`PTW_PAGE_SHIFT])
				hit = 1'b1;
		end
		// Oldest valid entry that has not been sent to the walker yet
		for (int i = 0; i < `PTW_MISSQ_SIZE; i++) begin
			if (q[i].valid && !q[i].issued && (!sel_found || age[i] > sel_age)) begin
				sel_found = 1'b1;
				sel_pos = QAW'(i);
				sel_age = age[i];
			end
		end
	end

	assign accept = miss_v && !miss_busy && !hit;
	assign done_age = age[done_stk[QAW-1:0]];

	assign sel_qe = sel_found ? missq_idx_t'(sel_pos) : MISSQ_NONE;
	assign sel_asid = q[sel_pos].asid;
	assign sel_vadr = q[sel_pos].vadr;

	// Entry control bits and payload
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `PTW_MISSQ_SIZE; i++) begin
				q[i].valid <= 1'b0;
				q[i].issued <= 1'b0;
			end
		end
		else begin
			if (accept)
				q[free_pos] <= '{valid: 1'b1, issued: 1'b0, asid: miss_asid, vadr: miss_vadr};
			if (!issue_qe[QAW])
				q[issue_qe[QAW-1:0]].issued <= 1'b1;
			// The freed entry is still valid this cycle, so it never collides with accept
			if (done_v)
				q[done_stk[QAW-1:0]].valid <= 1'b0;
		end
	end

	// Ages: every allocation makes the others older, a release closes the gap
	always_ff @(posedge clk) begin
		for (int i = 0; i < `PTW_MISSQ_SIZE; i++) begin
			if (accept && q[i].valid && !(done_v && age[i] > done_age))
				age[i] <= age[i] + 1'b1;
			else if (!(accept && q[i].valid) && done_v && q[i].valid && age[i] > done_age)
				age[i] <= age[i] - 1'b1;
		end
		if (accept)
			age[free_pos] <= '0;
	end

	// A completion from the buffer must name an entry the walker actually issued
	a_done_valid: assert property (@(posedge clk) disable iff (rst)
		done_v |-> !done_stk[QAW] && q[done_stk[QAW-1:0]].valid &&
			q[done_stk[QAW-1:0]].issued)
		else $error("done_v names an entry that is not outstanding");

endmodule

//--- hdl/ptw_walker.sv
// Walker FSM for a one-level page table.
// It alternates IDLE and ISSUE, so at most one PTE read starts every two cycles.
// A walk starts only while the buffer slot of the current id is free.
// The PTE address is ptbr plus eight times the virtual page number, and
// ptbr must stay stable while misses are pending.

`include "ptw_settings.svh"

module ptw_walker import ptw_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  missq_idx_t sel_qe,
	input  asid_t      sel_asid,
	input  vadr_t      sel_vadr,
	input  padr_t      ptbr,
	input  tran_id_t   tid,
	input  logic       slot_busy,
	output ptw_state_t state,
	output missq_idx_t issue_qe,
	output logic       ptw_pv,
	output vadr_t      ptw_vadr,
	output padr_t      ptw_padr,
	output asid_t      ptw_asid,
	output missq_idx_t ptw_stk,
	output logic       mem_req,
	output padr_t      mem_adr,
	output tran_id_t   mem_tid
);

	logic go;

	// Start a walk when a miss is selected and the next slot is free
	assign go = state == IDLE && !sel_qe[3] && !slot_busy;

	// Mark the entry issued in the same edge that latches it
	assign issue_qe = go ? sel_qe : MISSQ_NONE;

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else begin
			case (state)
			IDLE:
				if (go)
					state <= ISSUE;
			ISSUE:
				state <= IDLE;
			default:
				state <= IDLE;
			endcase
		end
	end

	// Walk context, loaded when leaving IDLE
	always_ff @(posedge clk) begin
		if (go) begin
			ptw_vadr <= sel_vadr;
			ptw_asid <= sel_asid;
			ptw_stk <= sel_qe;
			ptw_padr <= ptbr + (padr_t'(sel_vadr[31:`PTW_PAGE_SHIFT]) << `PTW_PTE_SHIFT);
		end
	end

	// One request and one record strobe per ISSUE cycle
	assign ptw_pv = state == ISSUE;
	assign mem_req = state == ISSUE;
	assign mem_adr = ptw_padr;
	assign mem_tid = tid;

	// Id 0 is reserved, so no request may leave with it
	a_req_tid: assert property (@(posedge clk) disable iff (rst)
		mem_req |-> mem_tid.tranid != 4'd0)
		else $error("mem_req carries the reserved transaction id 0");

endmodule

//--- hdl/ptw_tran_buffer.sv
// Transaction buffer for outstanding PTE reads, indexed by transaction id.
// Responses may come back in any order; each must carry an id in flight.
// Ready slots retire lowest first, one per cycle, and the update must be
// taken in the cycle it is offered. upd_fault is high for a PTE whose
// valid bit is clear.

`include "ptw_settings.svh"

module ptw_tran_buffer import ptw_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  ptw_state_t   state,
	input  logic         ptw_pv,
	input  vadr_t        ptw_vadr,
	input  padr_t        ptw_padr,
	input  asid_t        ptw_asid,
	input  missq_idx_t   ptw_stk,
	input  logic         mem_ack,
	input  tran_id_t     mem_ack_tid,
	input  logic [127:0] mem_dat,
	output tran_id_t     tid,
	output logic         slot_busy,
	output logic         done_v,
	output missq_idx_t   done_stk,
	output logic         upd_v,
	output asid_t        upd_asid,
	output vadr_t        upd_vadr,
	output pte_t         upd_pte,
	output logic         upd_fault
);

	localparam int SAW = $clog2(`PTW_TRAN_SLOTS);

	tran_buf_t      tranbuf [`PTW_TRAN_SLOTS];
	slot_idx_t      sel_tran;
	logic           rdy_found;
	logic [SAW-1:0] rdy_pos;
	logic [SAW-1:0] cur;

	assign slot_busy = tranbuf[tid.tranid].v;

	// Lowest ready slot, skipping the one that retires this cycle
	always_comb begin
		rdy_found = 1'b0;
		rdy_pos = '0;
		for (int i = `PTW_TRAN_SLOTS - 1; i >= 0; i--) begin
			if (tranbuf[i].v && tranbuf[i].rdy && (sel_tran[SAW] || sel_tran[SAW-1:0] != i)) begin
				rdy_found = 1'b1;
				rdy_pos = SAW'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tid <= '{core: `PTW_CORENO, channel: `PTW_CHANNEL, tranid: 4'd1};
			sel_tran <= SLOT_NONE;
			for (int i = 0; i < `PTW_TRAN_SLOTS; i++) begin
				tranbuf[i].v <= 1'b0;
				tranbuf[i].rdy <= 1'b0;
			end
		end
		else begin
			// ==============================
			// Record the read issued by the walker
			// ==============================
			if (state == ISSUE && ptw_pv) begin
				tranbuf[tid.tranid].v <= 1'b1;
				tranbuf[tid.tranid].rdy <= 1'b0;
				tranbuf[tid.tranid].id <= tid;
				tranbuf[tid.tranid].asid <= ptw_asid;
				tranbuf[tid.tranid].vadr <= ptw_vadr;
				tranbuf[tid.tranid].padr <= ptw_padr;
				tranbuf[tid.tranid].stk <= ptw_stk;
				// Id 0 is reserved, so the counter skips it on wrap
				tid.tranid <= (&tid.tranid) ? 4'd1 : tid.tranid + 4'd1;
			end

			// Capture the returned line
			if (mem_ack) begin
				tranbuf[mem_ack_tid.tranid].dat <= mem_dat;
				tranbuf[mem_ack_tid.tranid].rdy <= 1'b1;
			end

			// Pick the next slot to retire and pull its PTE out of the line
			sel_tran <= rdy_found ? slot_idx_t'(rdy_pos) : SLOT_NONE;
			if (rdy_found)
				tranbuf[rdy_pos].pte <= tranbuf[rdy_pos].padr[`PTW_PTE_SHIFT] ?
					tranbuf[rdy_pos].dat[127:64] : tranbuf[rdy_pos].dat[63:0];

			// Retire the slot selected last cycle
			if (!sel_tran[SAW]) begin
				tranbuf[sel_tran[SAW-1:0]].v <= 1'b0;
				tranbuf[sel_tran[SAW-1:0]].rdy <= 1'b0;
			end
		end
	end

	// Update and release strobes come straight from the selected slot
	assign cur = sel_tran[SAW-1:0];
	assign upd_v = !sel_tran[SAW];
	assign done_v = !sel_tran[SAW];
	assign done_stk = tranbuf[cur].stk;
	assign upd_asid = tranbuf[cur].asid;
	assign upd_vadr = tranbuf[cur].vadr;
	assign upd_pte = tranbuf[cur].pte;
	assign upd_fault = !tranbuf[cur].pte[0];

	a_ack_outstanding: assert property (@(posedge clk) disable iff (rst)
		mem_ack |-> tranbuf[mem_ack_tid.tranid].v && !tranbuf[mem_ack_tid.tranid].rdy &&
			tranbuf[mem_ack_tid.tranid].id == mem_ack_tid)
		else $error("mem_ack for an id that is not outstanding");

	// The walker checked the slot one cycle earlier, in IDLE
	a_record_free: assert property (@(posedge clk) disable iff (rst)
		ptw_pv |-> !tranbuf[tid.tranid].v)
		else $error("slot recorded while still valid");

endmodule

//--- hdl/ptw_top.sv
// Page-table walker top level.
// Misses enter from the TLB, PTE reads go to memory, and finished
// translations return to the TLB as single-cycle update strobes.
// Only miss_busy pushes back; everything else must be taken when offered.

module ptw_top import ptw_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	// TLB miss side
	input  logic         miss_v,
	input  asid_t        miss_asid,
	input  vadr_t        miss_vadr,
	output logic         miss_busy,
	// TLB update side
	output logic         upd_v,
	output asid_t        upd_asid,
	output vadr_t        upd_vadr,
	output pte_t         upd_pte,
	output logic         upd_fault,
	// Memory side
	output logic         mem_req,
	output padr_t        mem_adr,
	output tran_id_t     mem_tid,
	input  logic         mem_ack,
	input  tran_id_t     mem_ack_tid,
	input  logic [127:0] mem_dat,
	// Page-table base register
	input  padr_t        ptbr
);

	missq_idx_t sel_qe;
	asid_t      sel_asid;
	vadr_t      sel_vadr;
	missq_idx_t issue_qe;
	ptw_state_t state;
	logic       ptw_pv;
	vadr_t      ptw_vadr;
	padr_t      ptw_padr;
	asid_t      ptw_asid;
	missq_idx_t ptw_stk;
	tran_id_t   tid;
	logic       slot_busy;
	logic       done_v;
	missq_idx_t done_stk;

	ptw_miss_queue u_miss_queue (
		.clk(clk), .rst(rst), .miss_v(miss_v), .miss_asid(miss_asid), .miss_vadr(miss_vadr),
		.issue_qe(issue_qe), .done_v(done_v), .done_stk(done_stk), .miss_busy(miss_busy),
		.sel_qe(sel_qe), .sel_asid(sel_asid), .sel_vadr(sel_vadr)
	);

	ptw_walker u_walker (
		.clk(clk), .rst(rst), .sel_qe(sel_qe), .sel_asid(sel_asid), .sel_vadr(sel_vadr),
		.ptbr(ptbr), .tid(tid), .slot_busy(slot_busy), .state(state), .issue_qe(issue_qe),
		.ptw_pv(ptw_pv), .ptw_vadr(ptw_vadr), .ptw_padr(ptw_padr), .ptw_asid(ptw_asid),
		.ptw_stk(ptw_stk), .mem_req(mem_req), .mem_adr(mem_adr), .mem_tid(mem_tid)
	);

	ptw_tran_buffer u_tran_buffer (
		.clk(clk), .rst(rst), .state(state), .ptw_pv(ptw_pv), .ptw_vadr(ptw_vadr),
		.ptw_padr(ptw_padr), .ptw_asid(ptw_asid), .ptw_stk(ptw_stk), .mem_ack(mem_ack),
		.mem_ack_tid(mem_ack_tid), .mem_dat(mem_dat), .tid(tid), .slot_busy(slot_busy),
		.done_v(done_v), .done_stk(done_stk), .upd_v(upd_v), .upd_asid(upd_asid),
		.upd_vadr(upd_vadr), .upd_pte(upd_pte), .upd_fault(upd_fault)
	);

endmodule

//--- testbench/tb_ptw.sv
// Testbench for the page-table walker.
// Misses come from a fixed table; memory answers each read after 1 to 8
// cycles, one response per cycle, so reads return out of order.
// Every 64-bit half of a line carries its own address in bits 51 to 12
// and the valid bit of the table page that maps there.
// All table pages differ except the pair that checks merging.

`include "ptw_settings.svh"

module tb_ptw import ptw_pkg::*; ();

	localparam int    N     = 22;
	localparam int    LIMIT = N * 40 + 200;
	localparam padr_t PTBR  = 32'h8000_0000;

	typedef struct packed {
		logic [63:0] name;
		asid_t       asid;
		vadr_t       vadr;
		logic [7:0]  gap;
		logic        valid;
	} row_t;

	// Name, ASID, vadr, idle cycles before the miss, expected PTE valid bit
	localparam row_t TABLE [N] = '{
		'{"odd_half", 8'h01, 32'h0000_1234, 8'd0,  1'b1},
		'{"evn_half", 8'h01, 32'h0000_2abc, 8'd20, 1'b1},
		'{"pte_flt0", 8'h02, 32'h0000_3008, 8'd20, 1'b0},
		'{"merge_a0", 8'h03, 32'h0001_0010, 8'd20, 1'b1},
		'{"merge_b0", 8'h03, 32'h0001_0ff0, 8'd0,  1'b1},
		'{"burst_00", 8'h04, 32'h0002_0000, 8'd20, 1'b1},
		'{"burst_01", 8'h05, 32'h0002_1008, 8'd0,  1'b1},
		'{"burst_02", 8'h06, 32'h0002_2ff8, 8'd0,  1'b0},
		'{"burst_03", 8'h07, 32'h0002_3100, 8'd0,  1'b1},
		'{"burst_04", 8'h04, 32'h0002_4010, 8'd0,  1'b1},
		'{"burst_05", 8'h05, 32'h0002_5abc, 8'd0,  1'b1},
		'{"burst_06", 8'h06, 32'h0002_6000, 8'd0,  1'b0},
		'{"burst_07", 8'h07, 32'h0002_7777, 8'd0,  1'b1},
		'{"burst_08", 8'h08, 32'h0002_8008, 8'd0,  1'b1},
		'{"burst_09", 8'h09, 32'h0002_9f00, 8'd0,  1'b1},
		'{"burst_10", 8'h0a, 32'h0002_a123, 8'd0,  1'b0},
		'{"burst_11", 8'h0b, 32'h0002_b456, 8'd0,  1'b1},
		'{"burst_12", 8'h0c, 32'h0002_c789, 8'd0,  1'b1},
		'{"burst_13", 8'h0d, 32'h0002_d000, 8'd0,  1'b1},
		'{"burst_14", 8'h0e, 32'h0002_eeee, 8'd0,  1'b0},
		'{"burst_15", 8'h0f, 32'h0002_f0f0, 8'd0,  1'b1},
		'{"burst_16", 8'h10, 32'h0003_0abc, 8'd0,  1'b1}
	};

	logic         clk;
	logic         rst;
	logic         miss_v;
	asid_t        miss_asid;
	vadr_t        miss_vadr;
	logic         miss_busy;
	logic         upd_v;
	asid_t        upd_asid;
	vadr_t        upd_vadr;
	pte_t         upd_pte;
	logic         upd_fault;
	logic         mem_req;
	padr_t        mem_adr;
	tran_id_t     mem_tid;
	logic         mem_ack;
	tran_id_t     mem_ack_tid;
	logic [127:0] mem_dat;
	padr_t        ptbr;

	integer     seed;
	int         cyc;
	int         errors;
	int         ndone;
	int         rejects;
	bit         pending [N];
	bit         req_seen [N];
	logic [3:0] row_tid [N];
	bit         tid_busy [16];
	logic [3:0] last_tid;
	bit         wrap_seen;

	// Reads waiting in the memory model
	padr_t    rq_adr [$];
	tran_id_t rq_tid [$];
	int       rq_due [$];

	ptw_top u_ptw_top (
		.clk(clk), .rst(rst), .miss_v(miss_v), .miss_asid(miss_asid), .miss_vadr(miss_vadr),
		.miss_busy(miss_busy), .upd_v(upd_v), .upd_asid(upd_asid), .upd_vadr(upd_vadr),
		.upd_pte(upd_pte), .upd_fault(upd_fault), .mem_req(mem_req), .mem_adr(mem_adr),
		.mem_tid(mem_tid), .mem_ack(mem_ack), .mem_ack_tid(mem_ack_tid), .mem_dat(mem_dat),
		.ptbr(ptbr)
	);

	// ==============================
	// Reference rules
	// ==============================
	function automatic padr_t pte_adr(vadr_t va);
		return PTBR + padr_t'({va[31:12], 3'b000});
	endfunction

	// Fill value of one 64-bit half, valid only if a table page maps to it
	function automatic pte_t fill_half(padr_t a);
		logic v;
		v = 1'b0;
		for (int i = 0; i < N; i++)
			if (pte_adr(TABLE[i].vadr) == a)
				v = TABLE[i].valid;
		return {20'h0, a, 11'h0, v};
	endfunction

	// Pending row with the same ASID and page, or -1
	function automatic int find_pending(asid_t asid, vadr_t va);
		int r;
		r = -1;
		for (int i = 0; i < N; i++)
			if (pending[i] && TABLE[i].asid == asid && TABLE[i].vadr[31:12] == va[31:12])
				r = i;
		return r;
	endfunction

	// Each pending row holds one queue entry, merged rows hold none
	function automatic int queued_count();
		int n;
		n = 0;
		for (int i = 0; i < N; i++)
			if (pending[i])
				n++;
		return n;
	endfunction

	task automatic compare(input string name, input string what, input logic [63:0] exp,
		input logic [63:0] act);
		assert (act === exp)
		else begin
			$display("error %s %s: expected %h, actual %h", name, what, exp, act);
			errors++;
		end
	endtask

	// ==============================
	// Clock, cycle count and timeout
	// ==============================
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc >= LIMIT) begin
			$display("timeout after %0d cycles, %0d of %0d tests finished", cyc, ndone, N);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Memory model answers the first matured read, at most one per cycle
	always @(posedge clk) begin
		int k;
		#2;
		k = -1;
		mem_ack = 1'b0;
		mem_ack_tid = '0;
		mem_dat = '0;
		for (int i = 0; i < rq_adr.size(); i++)
			if (k < 0 && rq_due[i] <= cyc)
				k = i;
		if (k >= 0) begin
			mem_ack = 1'b1;
			mem_ack_tid = rq_tid[k];
			mem_dat = {fill_half({rq_adr[k][31:4], 4'h8}), fill_half({rq_adr[k][31:4], 4'h0})};
			rq_adr.delete(k);
			rq_tid.delete(k);
			rq_due.delete(k);
		end
	end

	// A read must belong to a pending miss, come once, and carry the next id
	task automatic note_request();
		int r;
		logic [3:0] exp_tid;
		r = -1;
		for (int i = 0; i < N; i++)
			if (pending[i] && pte_adr(TABLE[i].vadr) == mem_adr)
				r = i;
		assert (r >= 0)
		else begin
			$display("read of address %h matches no pending miss", mem_adr);
			errors++;
		end
		if (r >= 0) begin
			assert (!req_seen[r])
			else begin
				$display("second read of address %h for one pending miss", mem_adr);
				errors++;
			end
			req_seen[r] = 1'b1;
			row_tid[r] = mem_tid.tranid;
		end
		exp_tid = (last_tid == 4'd15) ? 4'd1 : last_tid + 4'd1;
		compare("id_order", "mem_tid", 64'({`PTW_CORENO, `PTW_CHANNEL, exp_tid}), 64'(mem_tid));
		assert (!tid_busy[mem_tid.tranid])
		else begin
			$display("transaction id %0d reused while still outstanding", mem_tid.tranid);
			errors++;
		end
		if (last_tid == 4'd15 && mem_tid.tranid == 4'd1)
			wrap_seen = 1'b1;
		tid_busy[mem_tid.tranid] = 1'b1;
		last_tid = mem_tid.tranid;
		rq_adr.push_back(mem_adr);
		rq_tid.push_back(mem_tid);
		rq_due.push_back(cyc + 1 + int'($unsigned($random(seed)) % 8));
	endtask

	task automatic note_update();
		int r;
		int e0;
		string nm;
		r = find_pending(upd_asid, upd_vadr);
		assert (r >= 0)
		else begin
			$display("update for asid %h vadr %h that no pending miss expects", upd_asid, upd_vadr);
			errors++;
		end
		if (r >= 0) begin
			e0 = errors;
			nm = $sformatf("%s", TABLE[r].name);
			compare(nm, "vadr", 64'(TABLE[r].vadr), 64'(upd_vadr));
			compare(nm, "pte", fill_half(pte_adr(TABLE[r].vadr)), upd_pte);
			compare(nm, "fault", 64'(!TABLE[r].valid), 64'(upd_fault));
			assert (req_seen[r])
			else begin
				$display("update for %s arrived without a memory read", nm);
				errors++;
			end
			pending[r] = 1'b0;
			tid_busy[row_tid[r]] = 1'b0;
			ndone++;
			$display("test %s: %s", nm, (errors == e0) ? "ok" : "mismatch");
		end
	endtask

	// Outputs are sampled mid-cycle, away from the drive time
	always @(negedge clk) begin
		if (!rst && mem_req)
			note_request();
		if (!rst && upd_v)
			note_update();
	end

	// Offer one table miss, repeating it while the queue reports busy
	task automatic offer_miss(input int r);
		int other;
		string nm;
		nm = $sformatf("%s", TABLE[r].name);
		repeat (TABLE[r].gap) begin
			@(posedge clk);
			#2;
		end
		miss_v = 1'b1;
		miss_asid = TABLE[r].asid;
		miss_vadr = TABLE[r].vadr;
		// The queue is full exactly when every entry holds a pending miss
		compare(nm, "miss_busy", 64'(queued_count() == `PTW_MISSQ_SIZE), 64'(miss_busy));
		while (miss_busy) begin
			rejects++;
			@(posedge clk);
			#2;
			compare(nm, "miss_busy", 64'(queued_count() == `PTW_MISSQ_SIZE), 64'(miss_busy));
		end
		other = find_pending(TABLE[r].asid, TABLE[r].vadr);
		if (other >= 0) begin
			ndone++;
			$display("test %s: merged into %s", TABLE[r].name, TABLE[other].name);
		end
		else
			pending[r] = 1'b1;
		@(posedge clk);
		#2;
		miss_v = 1'b0;
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		seed = 32'hdf9de2b1;
		cyc = 0;
		errors = 0;
		ndone = 0;
		rejects = 0;
		last_tid = 4'd0;
		wrap_seen = 1'b0;
		rst = 1'b1;
		miss_v = 1'b0;
		miss_asid = '0;
		miss_vadr = '0;
		mem_ack = 1'b0;
		mem_ack_tid = '0;
		mem_dat = '0;
		ptbr = PTBR;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int r = 0; r < N; r++)
			offer_miss(r);
		while (ndone < N)
			@(posedge clk);
		// Leave room for any stray update or read
		repeat (20) @(posedge clk);
		assert (wrap_seen)
		else begin
			$display("transaction ids never wrapped from 15 to 1");
			errors++;
		end
		assert (rejects > 0)
		else begin
			$display("miss queue never reported busy during the burst");
			errors++;
		end
		$display("tests %0d, finished %0d, errors %0d, busy rejections %0d",
			N, ndone, errors, rejects);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- list.f
+incdir+hdl
hdl/ptw_pkg.sv
hdl/ptw_miss_queue.sv
hdl/ptw_walker.sv
hdl/ptw_tran_buffer.sv
hdl/ptw_top.sv
testbench/tb_ptw.sv

//--- Makefile
# Verilator build and run for the page-table walker testbench
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_ptw
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
